// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/10ps -j 0
TOP       = tb_exe_mem
FILELIST  = tb.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf $(BUILD)

// ==== alu.sv ====
// Base integer ALU
`default_nettype none
`timescale 1ns/10ps

module alu (
    input  wire rv_pkg::alu_op_t op_i,
    input  wire rv_pkg::xlen_t   a_i,
    input  wire rv_pkg::xlen_t   b_i,
    output rv_pkg::xlen_t        result_o
);

    import rv_pkg::*;

    logic [4:0] shamt; // only the low five bits of b shift
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb
    begin
        case (op_i)
            ALU_ADD:    result_o = a_i + b_i;
            ALU_SUB:    result_o = a_i - b_i;
            ALU_SLL:    result_o = a_i << shamt;
            ALU_SLT:    result_o = {31'd0, lt_signed};
            ALU_SLTU:   result_o = {31'd0, lt_unsigned};
            ALU_XOR:    result_o = a_i ^ b_i;
            ALU_SRL:    result_o = a_i >> shamt;
            ALU_SRA:    result_o = xlen_t'($signed(a_i) >>> shamt);
            ALU_OR:     result_o = a_i | b_i;
            ALU_AND:    result_o = a_i & b_i;
            ALU_PASS_B: result_o = b_i;
            default:    result_o = '0; // M ops are handled by muldiv
        endcase
    end

endmodule

`default_nettype wire

// ==== exe_mem_top.sv ====
// Execute and memory pipeline top
`default_nettype none
`timescale 1ns/10ps

module exe_mem_top #(
    parameter int DMEM_WORDS = 256 // must be a power of two
) (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire rv_pkg::issue_t issue_i,
    output logic                busy_o,
    output rv_pkg::wb_t         wb_o
);

    import rv_pkg::*;

    ex_mem_t ex_mem; // execute to memory pipeline register

    // issue_i must be held while busy_o is high
    exe_stage i_exe_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .issue_i  (issue_i),
        .ex_mem_o (ex_mem),
        .busy_o   (busy_o)
    );

    mem_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_mem_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .ex_mem_i (ex_mem),
        .wb_o     (wb_o)
    );

endmodule

`default_nettype wire

// ==== exe_stage.sv ====
// Execute stage with pipeline register
`default_nettype none
`timescale 1ns/10ps

module exe_stage (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire rv_pkg::issue_t issue_i,
    output rv_pkg::ex_mem_t     ex_mem_o,
    output logic                busy_o
);

    import rv_pkg::*;

    xlen_t   op_b;
    xlen_t   alu_res;
    xlen_t   md_res;
    xlen_t   exe_res;  // result of either unit, also the memory address
    xlen_t   rd_val;
    xlen_t   store_data;
    ex_mem_t ex_next;

    assign op_b    = issue_i.use_imm ? issue_i.imm : issue_i.rs2_val;
    assign exe_res = issue_i.alu_op[4] ? md_res : alu_res;

    alu i_alu (
        .op_i     (issue_i.alu_op),
        .a_i      (issue_i.rs1_val),
        .b_i      (op_b),
        .result_o (alu_res)
    );

    muldiv i_muldiv (
        .clk      (clk),
        .rst_n    (rst_n),
        .op_i     (issue_i.alu_op),
        .a_i      (issue_i.rs1_val),
        .b_i      (op_b),
        .result_o (md_res),
        .busy_o   (busy_o)
    );

    always_comb
    begin
        case (issue_i.wb_sel)
            WB_ALU:  rd_val = exe_res;
            WB_LINK: rd_val = issue_i.use_pc4 ? issue_i.pc4 : issue_i.brj_pc;
            default: rd_val = '0;
        endcase
    end

    // store data sits in the low lanes here and is moved to its lane in mem_stage
    always_comb
    begin
        case (issue_i.store_op)
            ST_SB:   store_data = {24'd0, issue_i.rs2_val[7:0]};
            ST_SH:   store_data = {16'd0, issue_i.rs2_val[15:0]};
            ST_SW:   store_data = issue_i.rs2_val;
            default: store_data = '0;
        endcase
    end

    always_comb
    begin
        ex_next.waddr      = issue_i.waddr;
        ex_next.reg_wr     = issue_i.reg_wr;
        ex_next.rd_val     = rd_val;
        ex_next.mem_addr   = exe_res;
        ex_next.mem_rd     = issue_i.mem_rd;
        ex_next.mem_wr     = (issue_i.store_op != ST_NONE);
        ex_next.store_op   = issue_i.store_op;
        ex_next.store_data = store_data;
        ex_next.load_op    = issue_i.load_op;
        if (busy_o)
        begin
            // muldiv still working, so a bubble goes down the pipe
            ex_next.reg_wr = 1'b0;
            ex_next.mem_rd = 1'b0;
            ex_next.mem_wr = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            ex_mem_o <= '0;
        else
            ex_mem_o <= ex_next;
    end

endmodule

`default_nettype wire

// ==== mem_stage.sv ====
// Data memory and write-back register
`default_nettype none
`timescale 1ns/10ps

module mem_stage #(
    parameter int DMEM_WORDS = 256
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rv_pkg::ex_mem_t ex_mem_i,
    output rv_pkg::wb_t          wb_o
);

    import rv_pkg::*;

    localparam int AW = $clog2(DMEM_WORDS);

    xlen_t          mem [DMEM_WORDS];
    logic [AW-1:0]  word_idx;
    logic [1:0]     lane;      // byte offset within the word
    logic [4:0]     lane_bits;
    logic [3:0]     byte_en;
    xlen_t          wr_data;
    xlen_t          rd_word;
    xlen_t          lane_word;
    xlen_t          load_val;

    assign word_idx  = ex_mem_i.mem_addr[AW+1:2];
    assign lane      = ex_mem_i.mem_addr[1:0];
    assign lane_bits = {lane, 3'b000};
    assign wr_data   = ex_mem_i.store_data << lane_bits;

    always_comb
    begin
        case (ex_mem_i.store_op)
            ST_SB:   byte_en = 4'b0001 << lane;
            ST_SH:   byte_en = 4'b0011 << lane;
            ST_SW:   byte_en = 4'b1111;
            default: byte_en = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (ex_mem_i.mem_wr)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (byte_en[b])
                    mem[word_idx][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

    // asynchronous read, so a load right after a store sees the new word
    assign rd_word   = mem[word_idx];
    assign lane_word = rd_word >> lane_bits;

    always_comb
    begin
        case (ex_mem_i.load_op)
            LD_LB:   load_val = {{24{lane_word[7]}}, lane_word[7:0]};
            LD_LH:   load_val = {{16{lane_word[15]}}, lane_word[15:0]};
            LD_LBU:  load_val = {24'd0, lane_word[7:0]};
            LD_LHU:  load_val = {16'd0, lane_word[15:0]};
            default: load_val = rd_word; // lw
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wb_o <= '0;
        else
        begin
            wb_o.waddr  <= ex_mem_i.waddr;
            wb_o.reg_wr <= ex_mem_i.reg_wr;
            wb_o.value  <= ex_mem_i.mem_rd ? load_val : ex_mem_i.rd_val;
        end
    end

endmodule

`default_nettype wire

// ==== muldiv.sv ====
// Iterative multiply and divide unit
`default_nettype none
`timescale 1ns/10ps

module muldiv (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire rv_pkg::alu_op_t op_i,
    input  wire rv_pkg::xlen_t   a_i,
    input  wire rv_pkg::xlen_t   b_i,
    output rv_pkg::xlen_t        result_o,
    output logic                 busy_o
);

    import rv_pkg::*;

    md_state_t   state;
    logic [4:0]  count;    // iteration counter for the 32 steps
    logic [63:0] acc;      // product, or remainder and quotient
    xlen_t       opb;      // multiplicand or divisor, as a magnitude
    logic [2:0]  f3_q;
    logic        neg_q;    // result needs negating at the end

    logic        is_m;
    logic        a_signed;
    logic        b_signed;
    logic        sa;
    logic        sb;
    xlen_t       abs_a;
    xlen_t       abs_b;
    logic [32:0] add_sum;
    logic [32:0] rem_shift;
    logic [32:0] rem_diff;
    logic [63:0] prod_fix;
    xlen_t       div_sel;
    xlen_t       div_fix;

    always_comb
    begin
        is_m     = op_i[4];
        // mul low half comes out the same whether treated as signed or not
        a_signed = op_i[2] ? ~op_i[0] : (op_i[1:0] != 2'b11);
        b_signed = op_i[2] ? ~op_i[0] : ~op_i[1];
        sa       = a_signed & a_i[31];
        sb       = b_signed & b_i[31];
        abs_a    = sa ? -a_i : a_i;
        abs_b    = sb ? -b_i : b_i;
    end

    assign busy_o = is_m && (state != MD_DONE);

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= MD_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                MD_IDLE:
                begin
                    if (is_m)
                    begin
                        state <= MD_RUN; // operands are captured on this edge
                        count <= '0;
                    end
                end
                MD_RUN:
                begin
                    count <= count + 5'd1;
                    if (count == 5'd31)
                        state <= MD_DONE;
                end
                default: state <= MD_IDLE; // done lasts exactly one cycle
            endcase
        end
    end

    // one shift-add step, and one restoring division step
    assign add_sum   = {1'b0, acc[63:32]} + (acc[0] ? {1'b0, opb} : 33'd0);
    assign rem_shift = {acc[63:32], acc[31]};
    assign rem_diff  = rem_shift - {1'b0, opb};

    always_ff @(posedge clk)
    begin
        if ((state == MD_IDLE) && is_m)
        begin
            f3_q <= op_i[2:0];
            acc  <= {32'd0, (op_i[2] ? abs_a : abs_b)};
            opb  <= op_i[2] ? abs_b : abs_a;
            if (!op_i[2])
                neg_q <= sa ^ sb;
            else if (op_i[1])
                neg_q <= sa; // remainder takes the sign of the dividend
            else
                neg_q <= (sa ^ sb) && (b_i != '0); // divide by zero stays all ones
        end
        else if (state == MD_RUN)
        begin
            if (!f3_q[2])
                acc <= {add_sum, acc[31:1]};
            else if (!rem_diff[32])
                acc <= {rem_diff[31:0], acc[30:0], 1'b1};
            else
                acc <= {rem_shift[31:0], acc[30:0], 1'b0};
        end
    end

    // signed overflow falls out of the magnitude path as the dividend
    assign prod_fix = neg_q ? -acc : acc;
    assign div_sel  = f3_q[1] ? acc[63:32] : acc[31:0];
    assign div_fix  = neg_q ? -div_sel : div_sel;

    always_comb
    begin
        if (f3_q[2])
            result_o = div_fix;
        else if (f3_q[1:0] == 2'b00)
            result_o = prod_fix[31:0];
        else
            result_o = prod_fix[63:32]; // mulh, mulhsu and mulhu
    end

endmodule

`default_nettype wire

// ==== rv_pkg.sv ====
// RV32IM execute and memory types
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;     // one data word
    typedef logic [4:0]  reg_addr_t; // register file index

    // bit 4 marks the M extension, whose low three bits follow funct3
    typedef enum logic [4:0] {
        ALU_ADD    = 5'b00000,
        ALU_SUB    = 5'b00001,
        ALU_SLL    = 5'b00010,
        ALU_SLT    = 5'b00011,
        ALU_SLTU   = 5'b00100,
        ALU_XOR    = 5'b00101,
        ALU_SRL    = 5'b00110,
        ALU_SRA    = 5'b00111,
        ALU_OR     = 5'b01000,
        ALU_AND    = 5'b01001,
        ALU_PASS_B = 5'b01010, // lui puts the immediate straight through
        ALU_MUL    = 5'b10000,
        ALU_MULH   = 5'b10001,
        ALU_MULHSU = 5'b10010,
        ALU_MULHU  = 5'b10011,
        ALU_DIV    = 5'b10100,
        ALU_DIVU   = 5'b10101,
        ALU_REM    = 5'b10110,
        ALU_REMU   = 5'b10111
    } alu_op_t;

    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_SB   = 2'd1,
        ST_SH   = 2'd2,
        ST_SW   = 2'd3
    } store_op_t;

    // encodings are the load funct3 values
    typedef enum logic [2:0] {
        LD_LB  = 3'b000,
        LD_LH  = 3'b001,
        LD_LW  = 3'b010,
        LD_LBU = 3'b100,
        LD_LHU = 3'b101
    } load_op_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_ZERO = 2'd1,
        WB_LINK = 2'd2 // pc4 or branch target, chosen by use_pc4
    } wb_sel_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;
        logic      use_pc4;
        wb_sel_t   wb_sel;
        store_op_t store_op;
        load_op_t  load_op;
        xlen_t     rs1_val;
        xlen_t     rs2_val;
        xlen_t     imm;
        xlen_t     pc4;
        xlen_t     brj_pc;
        reg_addr_t waddr;
        logic      reg_wr;
        logic      mem_rd;
    } issue_t;

    typedef struct packed {
        reg_addr_t waddr;
        logic      reg_wr;
        xlen_t     rd_val;
        xlen_t     mem_addr;
        logic      mem_rd;
        logic      mem_wr;
        store_op_t store_op;
        xlen_t     store_data;
        load_op_t  load_op;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t waddr;
        logic      reg_wr;
        xlen_t     value;
    } wb_t;

    typedef enum logic [1:0] {
        MD_IDLE = 2'd0,
        MD_RUN  = 2'd1,
        MD_DONE = 2'd2
    } md_state_t;

endpackage

`default_nettype wire

// ==== tb.f ====
rv_pkg.sv
alu.sv
muldiv.sv
exe_stage.sv
mem_stage.sv
exe_mem_top.sv
tb_clock.sv
tb_exe_mem.sv

// ==== tb_clock.sv ====
// Testbench clock source
`default_nettype none
`timescale 1ns/10ps

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk_o
);

    initial clk_o = 1'b0;

    always #(PERIOD_NS / 2) clk_o = ~clk_o; // 50 percent duty cycle

endmodule

`default_nettype wire

// ==== tb_exe_mem.sv ====
// Execute and memory pipeline testbench
`default_nettype none
`timescale 1ns/10ps

module tb_exe_mem;

    import rv_pkg::*;

    localparam int DMEM_WORDS    = 256;
    localparam int N_BASE        = 200;
    localparam int N_MULDIV      = 60;
    localparam int N_WBSEL       = 30;
    localparam int N_MEM         = 64;
    localparam int N_PAIRS       = 20;
    localparam int N_MIXED       = 150;
    localparam int N_RESET       = 10;
    localparam int M_BUSY_CYCLES = 33;
    localparam int N_TOTAL       = N_BASE + N_MULDIV + N_WBSEL + 2 * N_MEM + 2 * N_PAIRS
                                   + N_MIXED + N_RESET + 4;
    // 40 cycles of 20 ns per instruction, with a margin for reset and draining
    localparam longint WATCHDOG_NS = longint'(N_TOTAL) * 40 * 20 + 5000;

    logic        clk;
    logic        rst_n;
    issue_t      issue_i;
    logic        busy_o;
    wb_t         wb_o;

    logic [31:0] rng_state = 32'he87e33f9;
    xlen_t       mirror [DMEM_WORDS]; // model copy of the data memory
    wb_t         exp_q [$];
    int          due_q [$];           // cycle at which each expected value is on wb_o
    int          cyc = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          test_checks;
    int          test_errors;

    tb_clock #(
        .PERIOD_NS (20)
    ) i_tb_clock (
        .clk_o (clk)
    );

    exe_mem_top #(
        .DMEM_WORDS (DMEM_WORDS)
    ) i_exe_mem_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue_i (issue_i),
        .busy_o  (busy_o),
        .wb_o    (wb_o)
    );

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // corner values turn up often so division edge cases get hit
    function automatic xlen_t pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 32'd0;
            3'd1:    return 32'h8000_0000;
            3'd2:    return 32'hffff_ffff;
            3'd3:    return 32'd1;
            default: return next_rand();
        endcase
    endfunction

    function automatic xlen_t align_addr(xlen_t a, int bytes);
        return a & ~(xlen_t'(bytes) - 32'd1);
    endfunction

    function automatic xlen_t base_result(alu_op_t op, xlen_t a, xlen_t b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a - b;
            ALU_SLL:    return a << sh;
            ALU_SLT:    return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            ALU_SLTU:   return {31'd0, a < b};
            ALU_XOR:    return a ^ b;
            ALU_SRL:    return a >> sh;
            ALU_SRA:    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_PASS_B: return b;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic xlen_t m_result(alu_op_t op, xlen_t a, xlen_t b);
        logic [63:0] ss;
        logic [63:0] su;
        logic [63:0] uu;
        logic        ovf;
        ss  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        su  = {{32{a[31]}}, a} * {32'd0, b};
        uu  = {32'd0, a} * {32'd0, b};
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (op)
            ALU_MUL:    return uu[31:0];
            ALU_MULH:   return ss[63:32];
            ALU_MULHSU: return su[63:32];
            ALU_MULHU:  return uu[63:32];
            ALU_DIV:    return (b == 32'd0) ? 32'hffff_ffff
                             : ovf ? a : xlen_t'($signed(a) / $signed(b));
            ALU_DIVU:   return (b == 32'd0) ? 32'hffff_ffff : a / b;
            ALU_REM:    return (b == 32'd0) ? a : ovf ? 32'd0 : xlen_t'($signed(a) % $signed(b));
            default:    return (b == 32'd0) ? a : a % b; // remu
        endcase
    endfunction

    function automatic issue_t nop_instr();
        issue_t ins;
        ins          = '0;
        ins.alu_op   = ALU_ADD;
        ins.wb_sel   = WB_ALU;
        ins.store_op = ST_NONE;
        ins.load_op  = LD_LW;
        return ins;
    endfunction

    function automatic issue_t rand_common();
        issue_t      ins;
        logic [31:0] r;
        ins         = nop_instr();
        r           = next_rand();
        ins.waddr   = r[4:0];
        ins.reg_wr  = r[5];
        ins.use_imm = r[6];
        ins.use_pc4 = r[7];
        ins.rs1_val = pick_operand();
        ins.rs2_val = pick_operand();
        ins.imm     = next_rand();
        ins.pc4     = next_rand();
        ins.brj_pc  = next_rand();
        return ins;
    endfunction

    function automatic issue_t gen_base();
        issue_t ins;
        ins        = rand_common();
        ins.alu_op = alu_op_t'(5'(next_rand() % 32'd11)); // codes 0 to 10 are the base set
        return ins;
    endfunction

    function automatic issue_t gen_muldiv();
        issue_t      ins;
        logic [31:0] r;
        ins         = rand_common();
        r           = next_rand();
        ins.alu_op  = alu_op_t'({2'b10, r[2:0]});
        ins.use_imm = 1'b0;
        ins.reg_wr  = 1'b1;
        return ins;
    endfunction

    function automatic issue_t gen_link();
        issue_t ins;
        ins        = gen_base();
        ins.wb_sel = next_rand() & 32'd1 ? WB_LINK : WB_ZERO;
        ins.reg_wr = 1'b1;
        return ins;
    endfunction

    function automatic issue_t gen_mem(xlen_t addr, store_op_t st, load_op_t ld);
        issue_t      ins;
        logic [31:0] r;
        ins          = rand_common();
        r            = next_rand();
        ins.alu_op   = ALU_ADD;
        ins.use_imm  = 1'b1;
        ins.imm      = {26'd0, r[5:0]};
        ins.rs1_val  = addr - ins.imm; // rs1 + imm lands on the wanted address
        ins.store_op = st;
        ins.load_op  = ld;
        ins.mem_rd   = (st == ST_NONE);
        ins.reg_wr   = (st == ST_NONE);
        return ins;
    endfunction

    function automatic load_op_t load_kind(int k);
        case (k % 5)
            0:       return LD_LB;
            1:       return LD_LH;
            2:       return LD_LW;
            3:       return LD_LBU;
            default: return LD_LHU;
        endcase
    endfunction

    function automatic issue_t gen_mixed(int limit);
        logic [31:0] r;
        xlen_t       addr;
        store_op_t   st;
        load_op_t    ld;
        r    = next_rand();
        st   = store_op_t'(2'(32'd1 + r[15:8] % 8'd3));
        ld   = load_kind(int'(r[23:16]));
        addr = next_rand() % xlen_t'(limit);
        case (r[2:0])
            3'd0, 3'd1: return gen_base();
            3'd2:       return gen_muldiv();
            3'd3:       return gen_link();
            3'd4, 3'd5: return gen_mem(align_addr(addr, 1 << (st - 1)), st, LD_LW);
            default:    return gen_mem(align_addr(addr, 1 << ld[1:0]), ST_NONE, ld);
        endcase
    endfunction

    // applies one instruction to the model, stores included
    task automatic model_apply(input issue_t ins, output wb_t exp);
        xlen_t b;
        xlen_t res;
        xlen_t rd;
        xlen_t lane_word;
        int    idx;
        int    sh;
        b   = ins.use_imm ? ins.imm : ins.rs2_val;
        res = ins.alu_op[4] ? m_result(ins.alu_op, ins.rs1_val, b)
                            : base_result(ins.alu_op, ins.rs1_val, b);
        case (ins.wb_sel)
            WB_ALU:  rd = res;
            WB_LINK: rd = ins.use_pc4 ? ins.pc4 : ins.brj_pc;
            default: rd = 32'd0;
        endcase
        idx = int'((res >> 2) % DMEM_WORDS);
        sh  = 8 * int'(res[1:0]);
        case (ins.store_op)
            ST_SB:   mirror[idx][sh +: 8] = ins.rs2_val[7:0];
            ST_SH:   mirror[idx][sh +: 16] = ins.rs2_val[15:0];
            ST_SW:   mirror[idx] = ins.rs2_val;
            default: ;
        endcase
        lane_word  = mirror[idx] >> sh;
        exp.waddr  = ins.waddr;
        exp.reg_wr = ins.reg_wr;
        exp.value  = rd;
        if (ins.mem_rd)
        begin
            case (ins.load_op)
                LD_LB:   exp.value = 32'($signed(lane_word[7:0]));
                LD_LH:   exp.value = 32'($signed(lane_word[15:0]));
                LD_LBU:  exp.value = 32'(lane_word[7:0]);
                LD_LHU:  exp.value = 32'(lane_word[15:0]);
                default: exp.value = mirror[idx];
            endcase
        end
    endtask

    task automatic clear_mirror();
        for (int i = 0; i < DMEM_WORDS; i++)
            mirror[i] = 32'd0;
    endtask

    task automatic check_wb(input wb_t got, input wb_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail wb_o: got waddr %h reg_wr %h value %h, exp waddr %h reg_wr %h value %h",
                     got.waddr, got.reg_wr, got.value, exp.waddr, exp.reg_wr, exp.value);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_busy_len(input int got, input int exp);
        checks++;
        if (got != exp)
        begin
            errors++;
            $display("Fail busy_o cycles high: got %h expected %h", got, exp);
        end
    endtask

    // waits until busy_o is low, which means the next rising edge accepts
    task automatic issue_one(input issue_t ins);
        wb_t exp;
        int  busy_cycles;
        busy_cycles = 0;
        @(negedge clk);
        issue_i = ins;
        #1;
        while (busy_o)
        begin
            busy_cycles++;
            @(negedge clk);
            #1;
        end
        model_apply(ins, exp);
        exp_q.push_back(exp);
        due_q.push_back(cyc + 2); // accepted at cyc + 1, on wb_o one edge later
        check_busy_len(busy_cycles, ins.alu_op[4] ? M_BUSY_CYCLES : 0);
    endtask

    task automatic drain();
        @(negedge clk);
        issue_i = nop_instr();
        while (due_q.size() > 0)
        begin
            @(negedge clk);
            #2;
        end
    endtask

    task automatic begin_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d errors", tests, name,
                 checks - test_checks, errors - test_errors);
    endtask

    always @(posedge clk)
        cyc <= cyc + 1;

    // wb_o settles after the rising edge, so it is compared on the falling one
    always @(negedge clk)
    begin
        if (due_q.size() > 0 && due_q[0] == cyc)
        begin
            check_wb(wb_o, exp_q.pop_front());
            void'(due_q.pop_front());
        end
        else
            check_level("wb_o.reg_wr", wb_o.reg_wr, 1'b0); // nothing due, so only bubbles
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped accepting instructions",
                 WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial
    begin
        issue_t    ins;
        xlen_t     addr;
        store_op_t st;
        load_op_t  ld;
        xlen_t     stored [$];
        issue_i = nop_instr();
        rst_n   = 1'b0;
        clear_mirror();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        begin_test();
        for (int i = 0; i < N_BASE; i++)
            issue_one(gen_base());
        drain();
        end_test("base ALU");

        begin_test();
        for (int i = 0; i < N_MULDIV; i++)
            issue_one(gen_muldiv());
        drain();
        end_test("multiply and divide");

        begin_test();
        for (int i = 0; i < N_WBSEL; i++)
            issue_one(gen_link());
        drain();
        end_test("write-back select");

        begin_test();
        for (int i = 0; i < N_MEM; i++)
        begin
            st   = store_op_t'(2'(32'd1 + next_rand() % 32'd3));
            addr = align_addr(next_rand() % xlen_t'(DMEM_WORDS * 4), 1 << (st - 1));
            stored.push_back(addr);
            issue_one(gen_mem(addr, st, LD_LW));
        end
        for (int i = 0; i < N_MEM; i++)
        begin
            ld   = load_kind(i);
            addr = align_addr(stored[i] | (next_rand() & 32'd3), 1 << ld[1:0]);
            issue_one(gen_mem(addr, ST_NONE, ld));
        end
        drain();
        end_test("stores then loads");

        begin_test();
        for (int i = 0; i < N_PAIRS; i++)
        begin
            st   = store_op_t'(2'(32'd1 + next_rand() % 32'd3));
            ld   = load_kind(int'(next_rand() % 32'd5));
            addr = align_addr(next_rand() % xlen_t'(DMEM_WORDS * 4), 4);
            issue_one(gen_mem(addr, st, LD_LW));
            issue_one(gen_mem(addr, ST_NONE, ld));
        end
        for (int i = 0; i < N_MIXED; i++)
            issue_one(gen_mixed(64)); // small window so stores and loads collide
        drain();
        end_test("back-to-back");

        begin_test();
        ins        = gen_base();
        ins.reg_wr = 1'b1;
        issue_one(ins);
        @(negedge clk);
        issue_i = gen_muldiv(); // reset lands while this one is still running
        @(negedge clk);
        rst_n      = 1'b0; // wb_o holds the base op result up to this edge
        ins        = gen_base();
        ins.reg_wr = 1'b1;
        issue_i    = ins;
        #1;
        check_level("busy_o", busy_o, 1'b0);
        check_level("wb_o.reg_wr", wb_o.reg_wr, 1'b0);
        repeat (2) @(negedge clk);
        issue_i = nop_instr();
        rst_n   = 1'b1;
        clear_mirror();
        issue_one(gen_muldiv()); // a full busy count shows muldiv went back to idle
        for (int i = 0; i < N_RESET; i++)
            issue_one(gen_mixed(64));
        drain();
        end_test("reset");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
